// ==== shbus_golden.txt ====
// columns: master write addr burst-1 | wdata0 wdata1 wdata2 wdata3 | exp_rdata0..3 (hex)
// master 0 owns addresses 2..9, master 1 owns 10..15, 0 and 1
0 0 8 0  0 0 0 0                                  0 0 0 0
1 0 c 0  0 0 0 0                                  0 0 0 0
0 1 3 0  a5a50003 0 0 0                           0 0 0 0
1 1 e 3  bead000e bead000f bead0000 bead0001      0 0 0 0
0 0 3 0  0 0 0 0                                  a5a50003 0 0 0
1 0 0 0  0 0 0 0                                  bead0000 0 0 0
0 1 4 3  11110004 22220005 33330006 44440007      0 0 0 0
1 0 1 0  0 0 0 0                                  bead0001 0 0 0
0 0 4 3  0 0 0 0                                  11110004 22220005 33330006 44440007
1 0 e 3  0 0 0 0                                  bead000e bead000f bead0000 bead0001
0 0 5 1  0 0 0 0                                  22220005 33330006 0 0
1 1 a 1  5a5a000a 5a5a000b 0 0                    0 0 0 0
0 1 2 1  cafe0002 cafe0003 0 0                    0 0 0 0
1 0 a 2  0 0 0 0                                  5a5a000a 5a5a000b 0 0
0 0 2 2  0 0 0 0                                  cafe0002 cafe0003 11110004 0
1 1 d 0  7777000d 0 0 0                           0 0 0 0
1 0 b 3  0 0 0 0                                  5a5a000b 0 7777000d bead000e
0 0 8 0  0 0 0 0                                  0 0 0 0

// ==== shbus.f ====
shbus_pkg.sv
shbus_master.sv
shbus_arbiter.sv
shbus_mem_slave.sv
shbus_top.sv
tb_shbus.sv

// ==== Makefile ====
TOP := tb_shbus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f shbus.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f shbus.f --top-module $(TOP) -o sim_shbus
	./obj_dir/sim_shbus | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_shbus.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_shbus;
    import shbus_pkg::*;

    localparam int MAX_LINES = 32;
    localparam int FIELDS    = 12;

    logic       clk;
    logic       rst_n;
    cmd_t [1:0] cmd;
    logic [1:0] cmd_valid;
    logic [1:0] cmd_ready;
    rsp_t [1:0] rsp;
    logic [1:0] rsp_valid;

    // one golden line is FIELDS words: m, w, addr, burst, wdata x4, expected rdata x4
    logic [31:0] gold [0:MAX_LINES*FIELDS-1];
    int          n_lines;
    int          line_of [2][MAX_LINES];
    int          n_of [2];
    int          issued_line [2];
    int          out_line [2];
    int          rsp_count [2];
    logic [1:0]  outstanding;
    int          value_errors;
    int          other_errors;
    int          cycles;
    int          cycle_limit;

    shbus_top i_shbus_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            value_errors++;
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_response(input int m, input int li);
        int base;
        int burst;
        base  = li * FIELDS;
        burst = int'(gold[base+3]);
        check_value($sformatf("rsp[%0d].write", m), gold[base+1], 32'(rsp[m].write));
        // words past the burst length carry nothing
        if (gold[base+1] == 32'd0) begin
            for (int k = 0; k <= burst; k++) begin
                check_value($sformatf("rsp[%0d].rdata[%0d]", m, k), gold[base+8+k],
                            rsp[m].rdata[k]);
            end
        end
    endtask

    task automatic load_queues();
        int m;
        n_of[0] = 0;
        n_of[1] = 0;
        n_lines = 0;
        // entries the file did not fill keep the fill pattern, whose master field is > 1
        while (n_lines < MAX_LINES && gold[n_lines*FIELDS] <= 32'd1) begin
            m = int'(gold[n_lines*FIELDS]);
            line_of[m][n_of[m]] = n_lines;
            n_of[m]++;
            n_lines++;
        end
        if (n_lines == 0) begin
            other_errors++;
            $display("no commands found in the golden file");
        end
    endtask

    // runs at 1 ns after a rising edge and returns there
    task automatic drive_master(input int m);
        int li;
        int base;
        int gap;
        for (int k = 0; k < n_of[m]; k++) begin
            li   = line_of[m][k];
            base = li * FIELDS;
            // both masters start in the same cycle, and each second command
            // is held valid while the first is still in flight
            gap = (k < 2) ? 0 : int'($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            cmd[m].write = gold[base+1][0];
            cmd[m].addr  = gold[base+2][ADDR_W-1:0];
            cmd[m].burst = gold[base+3][1:0];
            for (int w = 0; w < MAX_BURST; w++) begin
                cmd[m].wdata[w] = gold[base+4+w];
            end
            issued_line[m] = li;
            cmd_valid[m]   = 1'b1;
            @(negedge clk);
            while (!cmd_ready[m]) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            cmd_valid[m] = 1'b0;
        end
    endtask

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            for (int m = 0; m < 2; m++) begin
                if (rsp_valid[m]) begin
                    if (!outstanding[m]) begin
                        other_errors++;
                        $display("master %0d gave a response with no command outstanding at %0t",
                                 m, $time);
                    end else begin
                        check_response(m, out_line[m]);
                    end
                    outstanding[m] = 1'b0;
                    rsp_count[m]++;
                end else if (outstanding[m] && cmd_ready[m]) begin
                    other_errors++;
                    $display("master %0d is ready for a command before its response at %0t",
                             m, $time);
                end
                if (cmd_valid[m] && cmd_ready[m]) begin
                    outstanding[m] = 1'b1;
                    out_line[m]    = issued_line[m];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, responses still missing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst_n           = 1'b0;
        cmd             = '0;
        cmd_valid       = '0;
        outstanding     = '0;
        rsp_count[0]    = 0;
        rsp_count[1]    = 0;
        issued_line[0]  = 0;
        issued_line[1]  = 0;
        value_errors    = 0;
        other_errors    = 0;
        cycles          = 0;
        cycle_limit     = 100000;
        void'($urandom(32'h97ce));
        for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
            gold[i] = 32'hf000_0000 | i;
        end
        $readmemh("shbus_golden.txt", gold);
        load_queues();
        cycle_limit = 40 * n_lines + 100;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("cmd_ready", 32'd3, 32'(cmd_ready));

        @(posedge clk);
        #1;
        fork
            drive_master(0);
            drive_master(1);
        join
        wait (rsp_count[0] == n_of[0] && rsp_count[1] == n_of[1]);
        // a few idle cycles catch stray responses
        repeat (10) @(posedge clk);

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== shbus_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module shbus_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  shbus_pkg::cmd_t [1:0] cmd,
    input  logic [1:0]            cmd_valid,
    output logic [1:0]            cmd_ready,
    output shbus_pkg::rsp_t [1:0] rsp,
    output logic [1:0]            rsp_valid
);
    import shbus_pkg::*;

    logic [1:0]      req;
    logic [1:0]      gnt;
    data_t [1:0]     m_wdata;
    bus_ctrl_t [1:0] m_ctrl;
    data_t           bus_wdata;
    bus_ctrl_t       bus_ctrl;
    data_t           bus_rdata;
    logic            bus_wait;

    // both masters see the same read data and wait
    for (genvar i = 0; i < 2; i++) begin : g_master
        shbus_master i_master (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd       (cmd[i]),
            .cmd_valid (cmd_valid[i]),
            .cmd_ready (cmd_ready[i]),
            .rsp       (rsp[i]),
            .rsp_valid (rsp_valid[i]),
            .req       (req[i]),
            .gnt       (gnt[i]),
            .bus_out   (m_wdata[i]),
            .ctrl_out  (m_ctrl[i]),
            .bus_in    (bus_rdata),
            .wait_in   (bus_wait)
        );
    end

    shbus_arbiter i_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .gnt       (gnt),
        .m_wdata   (m_wdata),
        .m_ctrl    (m_ctrl),
        .bus_wdata (bus_wdata),
        .bus_ctrl  (bus_ctrl)
    );

    shbus_mem_slave i_mem_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_wdata (bus_wdata),
        .bus_ctrl  (bus_ctrl),
        .bus_rdata (bus_rdata),
        .wait_out  (bus_wait)
    );

endmodule

`default_nettype wire

// ==== shbus_mem_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module shbus_mem_slave (
    input  logic                 clk,
    input  logic                 rst_n,
    input  shbus_pkg::data_t     bus_wdata,
    input  shbus_pkg::bus_ctrl_t bus_ctrl,
    output shbus_pkg::data_t     bus_rdata,
    output logic                 wait_out
);
    import shbus_pkg::*;

    typedef logic [$clog2(SLAVE_WAIT_CYCLES + 1)-1:0] wait_cnt_t;

    data_t             mem [MEM_WORDS];
    logic [ADDR_W-1:0] base_q;
    logic              write_q;
    burst_t            burst_q;
    burst_t            beat;
    logic              active;
    wait_cnt_t         wait_cnt;
    logic [ADDR_W-1:0] beat_addr;
    logic              beat_en;

    // offset add truncates, so the burst wraps at the top word
    assign beat_addr = base_q + ADDR_W'(beat);
    assign beat_en   = active && (bus_ctrl.phase == PH_DATA);
    assign wait_out  = (wait_cnt != '0);
    assign bus_rdata = (beat_en && !write_q) ? mem[beat_addr] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            active   <= 1'b0;
            beat     <= '0;
        end else begin
            if (bus_ctrl.phase == PH_ADDR) begin
                wait_cnt <= wait_cnt_t'(SLAVE_WAIT_CYCLES);
                active   <= 1'b1;
                beat     <= '0;
            end else begin
                if (wait_out) begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
                if (beat_en) begin
                    beat <= beat + 1'b1;
                    // transfer closes on its last beat
                    if (beat == burst_q) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    // address phase fields
    always_ff @(posedge clk) begin
        if (bus_ctrl.phase == PH_ADDR) begin
            base_q  <= bus_wdata[ADDR_W-1:0];
            write_q <= bus_ctrl.write;
            burst_q <= bus_ctrl.burst;
        end
    end

    // array starts out all zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (beat_en && write_q) begin
            mem[beat_addr] <= bus_wdata;
        end
    end

    // masters must wait out the full slave wait before any beat
    a_no_data_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_ctrl.phase == PH_DATA) |-> !wait_out)
        else $error("data beat while wait is high");

endmodule

`default_nettype wire

// ==== shbus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module shbus_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [1:0]                 req,
    output logic [1:0]                 gnt,
    input  shbus_pkg::data_t [1:0]     m_wdata,
    input  shbus_pkg::bus_ctrl_t [1:0] m_ctrl,
    output shbus_pkg::data_t           bus_wdata,
    output shbus_pkg::bus_ctrl_t       bus_ctrl
);
    import shbus_pkg::*;

    logic       last;
    logic       owner_busy;
    logic [1:0] gnt_nxt;

    assign owner_busy = |(gnt & req);

    // hold the owner, otherwise the one not served last wins
    always_comb begin
        if (owner_busy) begin
            gnt_nxt = gnt;
        end else if (req == 2'b11) begin
            gnt_nxt = last ? 2'b01 : 2'b10;
        end else begin
            gnt_nxt = req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt  <= '0;
            last <= 1'b1;
        end else begin
            gnt <= gnt_nxt;
            if (!owner_busy && (|gnt_nxt)) begin
                last <= gnt_nxt[1];
            end
        end
    end

    always_comb begin
        bus_wdata = '0;
        bus_ctrl  = '{phase: PH_IDLE, write: 1'b0, burst: '0};
        if (gnt[0]) begin
            bus_wdata = m_wdata[0];
            bus_ctrl  = m_ctrl[0];
        end else if (gnt[1]) begin
            bus_wdata = m_wdata[1];
            bus_ctrl  = m_ctrl[1];
        end
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt))
        else $error("more than one grant");

endmodule

`default_nettype wire

// ==== shbus_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module shbus_master (
    input  logic                 clk,
    input  logic                 rst_n,
    input  shbus_pkg::cmd_t      cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output shbus_pkg::rsp_t      rsp,
    output logic                 rsp_valid,
    output logic                 req,
    input  logic                 gnt,
    output shbus_pkg::data_t     bus_out,
    output shbus_pkg::bus_ctrl_t ctrl_out,
    input  shbus_pkg::data_t     bus_in,
    input  logic                 wait_in
);
    import shbus_pkg::*;

    mst_state_e            state;
    mst_state_e            state_nxt;
    burst_t                beat;
    cmd_t                  cmd_q;
    data_t [MAX_BURST-1:0] rdata_q;
    logic                  accept;
    logic                  last_beat;

    assign cmd_ready = (state == ST_IDLE);
    assign accept    = cmd_valid && cmd_ready;
    assign last_beat = (beat == cmd_q.burst);

    // req spans the whole transfer up to the last beat
    assign req = (state == ST_REQ) || (state == ST_ADDR) || (state == ST_WAIT) ||
                 (state == ST_WRITE) || (state == ST_READ);

    assign rsp_valid = (state == ST_FINISH);
    assign rsp.write = cmd_q.write;
    assign rsp.rdata = rdata_q;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_REQ;
                end
            end
            ST_REQ: begin
                if (gnt) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                state_nxt = ST_WAIT;
            end
            ST_WAIT: begin
                // slave lowers wait when it is ready for beats
                if (gnt && !wait_in) begin
                    state_nxt = cmd_q.write ? ST_WRITE : ST_READ;
                end
            end
            ST_WRITE, ST_READ: begin
                if (last_beat) begin
                    state_nxt = ST_FINISH;
                end
            end
            ST_FINISH: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            beat  <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_WRITE || state == ST_READ) begin
                beat <= last_beat ? '0 : beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
        if (state == ST_READ) begin
            rdata_q[beat] <= bus_in;
        end
    end

    // address in ADDR, write word n in beat n
    always_comb begin
        bus_out        = '0;
        ctrl_out.phase = PH_IDLE;
        ctrl_out.write = cmd_q.write;
        ctrl_out.burst = cmd_q.burst;
        case (state)
            ST_ADDR: begin
                bus_out        = data_t'(cmd_q.addr);
                ctrl_out.phase = PH_ADDR;
            end
            ST_WRITE: begin
                bus_out        = cmd_q.wdata[beat];
                ctrl_out.phase = PH_DATA;
            end
            ST_READ: begin
                ctrl_out.phase = PH_DATA;
            end
            default: begin
            end
        endcase
    end

    // the arbiter must not lose this master mid-transfer
    a_gnt_held: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_WAIT || state == ST_WRITE || state == ST_READ) |-> gnt)
        else $error("grant lost before the last beat");

    a_addr_granted: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_ADDR) |-> gnt)
        else $error("address phase without grant");

endmodule

`default_nettype wire

// ==== shbus_pkg.sv ====
`default_nettype none

package shbus_pkg;

    // bus and memory geometry
    localparam int DATA_W            = 32;
    localparam int ADDR_W            = 4;
    localparam int MEM_WORDS         = 16;
    localparam int MAX_BURST         = 4;
    localparam int SLAVE_WAIT_CYCLES = 2;

    typedef logic [DATA_W-1:0] data_t;

    // burst length minus one
    typedef logic [1:0] burst_t;

    // what a master drives on the bus this cycle
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ADDR,
        PH_DATA
    } bus_phase_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_ADDR,
        ST_WAIT,
        ST_WRITE,
        ST_READ,
        ST_FINISH
    } mst_state_e;

    typedef struct packed {
        logic                  write;
        logic [ADDR_W-1:0]     addr;
        burst_t                burst;
        data_t [MAX_BURST-1:0] wdata;
    } cmd_t;

    typedef struct packed {
        logic                  write;
        data_t [MAX_BURST-1:0] rdata;
    } rsp_t;

    // master to slave control, travels next to the muxed word
    typedef struct packed {
        bus_phase_e phase;
        logic       write;
        burst_t     burst;
    } bus_ctrl_t;

endpackage

`default_nettype wire
